//--- sim/am_lock_input.txt
// block (66 bit hex) | gaps (1 = random valid gaps) | lock (1 normal, 0 block lock low, 2 enable low)
// last column is the expected o_error_counter at the end of the period, hex
2594BE8E7A6B41718 0 0 0    // no block lock, stays in search
2594BE8E7A6B41718 1 0 0
2594BE8E7A6B41718 0 2 0    // enable low, stays in search
2594BE8E7A6B41718 0 1 0    // lane 2 found
2594BE8E7A6B41718 0 1 0
2594BE8E7A6B41718 0 1 0    // third good marker, lock
2594BE8E7A6B41718 1 1 0    // first locked marker opens bip period
2594BE8E7A6B41718 1 1 0
2594BE800A6B417FF 1 1 1    // wrong bip3
2594BE8E7A6B41718 1 1 1
2594BE800A6B417FF 0 1 2
2594BE800A6B417FF 1 1 3
2D9CBE8E7A6B41718 1 1 3    // one bad marker
2594BE8E7A6B41718 1 1 3    // good marker keeps lock
2D9CBE8E7A6B41718 1 1 3
2D9CBE8E7A6B41718 1 1 0    // second bad marker, resync clears count
2594BE8E7A6B41618 1 1 0    // m6 bit 0 flipped, masked out
2594BE8E7A6B41718 1 1 0
2594BE8E7A6B41618 0 1 0
2594BE8E7A6B41718 1 1 0
2594BE800A6B417FF 1 1 1
2594BE8E7A6B41718 1 1 1
2594BE8E7A6B41718 1 0 0    // block lock lost while locked
2594BE8E7A6B41718 1 1 0
2594BE8E7A6B41718 1 1 0
2594BE8E7A6B41718 1 1 0
2594BE8E7A6B41718 1 1 0
2594BE800A6B417FF 1 1 1
2594BE8E7A6B41718 1 2 0    // enable cleared while locked
2594BE8E7A6B41718 1 1 0
2D9CBE8E7A6B41718 1 1 0    // miss before lock, back to search
2594BE8E7A6B41718 1 1 0
2594BE8E7A6B41718 1 1 0
2594BE8E7A6B41718 1 1 0
2594BE8E7A6B41718 1 1 0

//--- compile.f
source/am_lock_pkg.sv
source/am_lock_comparator.sv
source/am_lock_fsm.sv
source/lane_id_decoder.sv
source/bip_calculator.sv
source/am_error_counter.sv
source/am_lock_module.sv
sim/am_lock_asserts.sv
sim/tb_am_lock.sv

//--- sim/tb_am_lock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_am_lock;

	localparam int N_ALIGNER  = 4;
	localparam int N_BLOCKS   = 7;                  // marker every 8 steps
	localparam int NB_ERROR   = 32;
	localparam int NB_LANE_ID = $clog2(N_ALIGNER);
	localparam int NB_VAL_AM  = $clog2(20);
	localparam int NB_INV_AM  = $clog2(8);
	localparam int VAL_THR    = 3;
	localparam int INV_THR    = 2;
	localparam int CLK_PERIOD = 40;
	localparam int MAX_LINES  = 64;
	localparam logic [47:0] COMPARE_MASK = 48'hFFFF_FFFF_FFFE;   // m6 bit 0 is don't care
	localparam int SEARCH     = 0;
	localparam int CHECK      = 1;
	localparam int LOCKED     = 2;

	logic                      clock = 1'b0;
	logic                      reset;
	logic                      rf_enable;
	logic                      valid;
	logic                      block_lock;
	am_lock_pkg::coded_block_u data_in;
	am_lock_pkg::coded_block_u data_out;
	logic [NB_LANE_ID-1:0]     lane_id;
	logic [NB_ERROR-1:0]       error_count;
	logic                      am_lock;
	logic                      resync;
	logic                      start_of_lane;

	logic [65:0] stim [0:4*MAX_LINES-1];          // four words per file line
	logic        stim_ready = 1'b0;               // line count known
	int          n_lines;
	int          word;
	int          seed;
	int          line;
	int          m_state;                         // reference model of the fsm
	int          m_timer;
	int          m_val;
	int          m_inv;
	int          m_lane;
	logic        m_resync;

	always #(CLK_PERIOD/2) clock = ~clock;

	am_lock_module #(
		.N_ALIGNER (N_ALIGNER),
		.N_BLOCKS  (N_BLOCKS)
	) i_dut (
		.i_clock             (clock),
		.i_reset             (reset),
		.i_rf_enable         (rf_enable),
		.i_valid             (valid),
		.i_block_lock        (block_lock),
		.i_data              (data_in),
		.i_rf_valid_am_thr   (NB_VAL_AM'(VAL_THR)),
		.i_rf_invalid_am_thr (NB_INV_AM'(INV_THR)),
		.i_rf_compare_mask   (COMPARE_MASK),
		.o_data              (data_out),
		.o_lane_id           (lane_id),
		.o_error_counter     (error_count),
		.o_am_lock           (am_lock),
		.o_resync            (resync),
		.o_start_of_lane     (start_of_lane)
	);

	task automatic check_value(input logic [65:0] actual, input logic [65:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("[FAIL] time %0t: %s is %h, expected %h", $time, what, actual, expected);
			$display("Checks failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// marker fields against one table lane under the compare mask
	function automatic logic marker_hit(input am_lock_pkg::coded_block_u blk, input int lane);
		logic [47:0] fields;
		fields = {blk.am.m0, blk.am.m1, blk.am.m2, blk.am.m4, blk.am.m5, blk.am.m6};
		return (blk.am.sh == am_lock_pkg::CTRL_SH) &&
			(((fields ^ am_lock_pkg::AM_TABLE[lane]) & COMPARE_MASK) == '0);
	endfunction

	task automatic check_outputs(input logic vld);
		logic sol;
		sol = vld && (m_state == LOCKED) && (m_timer == N_BLOCKS);   // expected marker slot
		check_value(start_of_lane, sol, "o_start_of_lane");
		check_value(am_lock, m_state == LOCKED, "o_am_lock");
		check_value(resync, m_resync, "o_resync");
		check_value(lane_id, (m_state == SEARCH) ? 0 : m_lane, "o_lane_id");
		check_value(data_out.raw, sol ? am_lock_pkg::IDLE_BLOCK : data_in.raw, "o_data");
	endtask

	// lock rules applied for the coming rising edge
	task automatic model_step(input logic vld, input logic lock_ok, input logic en);
		logic done;
		logic hit;
		int   lane;
		done = (m_timer == N_BLOCKS);
		if (!en || !lock_ok)
		begin
			m_resync = (m_state == LOCKED);         // only a held lock resyncs
			m_state  = SEARCH;
			m_timer  = 0;
			m_val    = 0;
			m_inv    = 0;
		end
		else
		begin
			m_resync = 1'b0;
			if (vld && m_state == SEARCH)
			begin
				hit = 1'b0;
				for (lane = 0; lane < N_ALIGNER; lane++)
					if (!hit && marker_hit(data_in, lane))
					begin
						hit    = 1'b1;
						m_lane = lane;
					end
				if (hit)
				begin
					m_state = (VAL_THR <= 1) ? LOCKED : CHECK;
					m_val   = 1;
					m_timer = 0;
				end
			end
			else if (vld)
			begin
				hit     = marker_hit(data_in, m_lane);   // stored lane only
				m_timer = done ? 0 : m_timer + 1;
				if (done && m_state == CHECK && hit)
				begin
					m_val++;
					if (m_val >= VAL_THR)
					begin
						m_state = LOCKED;
						m_inv   = 0;
					end
				end
				else if (done && m_state == CHECK)
					m_state = SEARCH;                   // miss before lock leaves without resync
				else if (done && hit)
					m_inv = 0;
				else if (done)
				begin
					m_inv++;
					if (m_inv >= INV_THR)
					begin
						m_state  = SEARCH;
						m_inv    = 0;
						m_resync = 1'b1;
					end
				end
			end
		end
	endtask

	task automatic drive_cycle(input logic [65:0] blk, input logic vld, input logic lock_ok,
		input logic en);
		@(negedge clock);
		data_in.raw = blk;
		valid       = vld;
		block_lock  = lock_ok;
		rf_enable   = en;
		#(CLK_PERIOD/4);                            // outputs settled before the edge
		check_outputs(vld);
		model_step(vld, lock_ok, en);
	endtask

	// each file line drives one marker period of the line's block and N_BLOCKS data blocks
	task automatic run_line(input int idx);
		logic [65:0] blk;
		logic [31:0] half;
		logic        gaps;
		logic        lock_ok;
		logic        en;
		int          step;
		gaps    = stim[4*idx+1][0];
		lock_ok = (stim[4*idx+2] != 0);             // code 0 drops block lock
		en      = (stim[4*idx+2] != 2);             // code 2 clears enable
		for (step = 0; step <= N_BLOCKS; step++)
		begin
			if (gaps && ($random(seed) & 1))
				drive_cycle(stim[4*idx], 1'b0, lock_ok, en);   // ignored marker in the gap
			half = $random(seed);
			blk  = (step == 0) ? stim[4*idx] : {2'b01, half, half};   // payload halves cancel
			drive_cycle(blk, 1'b1, lock_ok, en);
		end
		check_value(error_count, stim[4*idx+3],
			$sformatf("o_error_counter after line %0d", idx + 1));
	endtask

	initial
	begin
		reset       = 1'b1;
		rf_enable   = 1'b0;
		valid       = 1'b0;
		block_lock  = 1'b0;
		data_in.raw = '0;
		seed        = 32'h9a9a_5b4f;
		m_state     = SEARCH;
		m_timer     = 0;
		m_val       = 0;
		m_inv       = 0;
		m_lane      = 0;
		m_resync    = 1'b0;
		for (word = 0; word < 4*MAX_LINES; word++)
			stim[word] = '1;                          // all ones marks words the file leaves unset
		$readmemh("sim/am_lock_input.txt", stim);
		n_lines = 0;
		while (n_lines < MAX_LINES && stim[4*n_lines] !== '1)
			n_lines++;
		if (n_lines == 0)
		begin
			$display("no stimulus lines could be read from the input file");
			$display("Checks failed");
			$fatal(1, "missing stimulus");
		end
		else
		begin
			stim_ready = 1'b1;
			repeat (8) @(negedge clock);
			reset = 1'b0;
			for (line = 0; line < n_lines; line++)
				run_line(line);
			if (i_dut.u_asserts.fail_count != 0)
			begin
				$display("assertion failures were reported during the run");
				$display("Checks failed");
				$fatal(1, "assertion failures");
			end
			else
			begin
				$display("All checks passed");
				$finish;
			end
		end
	end

	// worst case is one gap per step
	initial
	begin
		wait (stim_ready);
		#((8 + n_lines * (N_BLOCKS + 1) * 4) * CLK_PERIOD);
		$display("watchdog expired: the stimulus did not finish in the expected time");
		$display("Checks failed");
		$fatal(1, "run stopped by the watchdog");
	end

endmodule

`default_nettype wire

//--- sim/am_lock_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module am_lock_asserts
#(
	parameter int NB_LANE_ID = 2
)
(
	input logic                  i_clock,
	input logic                  i_reset,
	input logic                  i_am_lock,
	input logic                  i_resync,
	input logic                  i_start_of_lane,
	input logic                  i_search,          // fsm in search
	input logic [NB_LANE_ID-1:0] i_lane_id
);

	int fail_count = 0;                           // read by the testbench at the end

	resync_on_unlock: assert property (@(posedge i_clock) disable iff (i_reset)
		i_resync |-> (!i_am_lock && $past(i_am_lock)))
	else
	begin
		fail_count++;
		$error("o_resync high without a lock loss");
	end

	resync_single: assert property (@(posedge i_clock) disable iff (i_reset)
		i_resync |=> !i_resync)
	else
	begin
		fail_count++;
		$error("o_resync longer than one cycle");
	end

	sol_needs_lock: assert property (@(posedge i_clock) disable iff (i_reset)
		i_start_of_lane |-> i_am_lock)
	else
	begin
		fail_count++;
		$error("o_start_of_lane without o_am_lock");
	end

	lane_zero_in_search: assert property (@(posedge i_clock) disable iff (i_reset)
		i_search |-> (i_lane_id == '0))
	else
	begin
		fail_count++;
		$error("o_lane_id not zero in search");
	end

endmodule

bind am_lock_module am_lock_asserts #(
	.NB_LANE_ID (NB_LANE_ID)
) u_asserts (
	.i_clock         (i_clock),
	.i_reset         (i_reset),
	.i_am_lock       (o_am_lock),
	.i_resync        (o_resync),
	.i_start_of_lane (o_start_of_lane),
	.i_search        (status.search),
	.i_lane_id       (o_lane_id)
);

`default_nettype wire

//--- source/am_lock_module.sv
`timescale 1ns/100ps
`default_nettype none

module am_lock_module
#(
	parameter int  N_ALIGNER        = 20,            // markers searched
	parameter int  N_BLOCKS         = 16383,         // data blocks between markers
	parameter int  NB_ERROR_COUNTER = 32,
	parameter int  MAX_VAL_AM       = 20,
	parameter int  MAX_INV_AM       = 8,
	localparam int NB_LANE_ID       = $clog2(N_ALIGNER),
	localparam int NB_VAL_AM        = $clog2(MAX_VAL_AM),
	localparam int NB_INV_AM        = $clog2(MAX_INV_AM)
)
(
	input  logic                          i_clock,
	input  logic                          i_reset,
	input  logic                          i_rf_enable,          // from register file
	input  logic                          i_valid,              // block strobe
	input  logic                          i_block_lock,         // from block sync
	input  am_lock_pkg::coded_block_u     i_data,               // from block sync
	input  logic [NB_VAL_AM-1:0]          i_rf_valid_am_thr,
	input  logic [NB_INV_AM-1:0]          i_rf_invalid_am_thr,
	input  logic [am_lock_pkg::NB_AM-1:0] i_rf_compare_mask,    // 0 = ignore bit
	output am_lock_pkg::coded_block_u     o_data,               // to deskew
	output logic [NB_LANE_ID-1:0]         o_lane_id,            // to lane reorder
	output logic [NB_ERROR_COUNTER-1:0]   o_error_counter,      // to register file
	output logic                          o_am_lock,
	output logic                          o_resync,
	output logic                          o_start_of_lane
);

	logic [N_ALIGNER-1:0]           match_mask;       // fsm to comparator and decoder
	logic [N_ALIGNER-1:0]           match_vector;     // comparator to fsm
	logic                           am_match;
	logic                           enable_mask;
	logic [am_lock_pkg::NB_BIP-1:0] calculated_bip;
	am_lock_pkg::am_status_t        status;

	// markers leave as idle control blocks
	assign o_data.raw = status.start_of_lane ? am_lock_pkg::IDLE_BLOCK : i_data.raw;

	assign o_am_lock       = status.am_lock;
	assign o_resync        = status.resync;
	assign o_start_of_lane = status.start_of_lane;

	am_lock_comparator #(
		.N_ALIGNER (N_ALIGNER)
	) u_am_lock_comparator (
		.i_block        (i_data),
		.i_compare_mask (i_rf_compare_mask),
		.i_match_mask   (match_mask),
		.i_enable_mask  (enable_mask),
		.o_am_match     (am_match),
		.o_match_vector (match_vector)
	);

	am_lock_fsm #(
		.N_ALIGNER  (N_ALIGNER),
		.N_BLOCKS   (N_BLOCKS),
		.MAX_VAL_AM (MAX_VAL_AM),
		.MAX_INV_AM (MAX_INV_AM)
	) u_am_lock_fsm (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_enable       (i_rf_enable),
		.i_valid        (i_valid),
		.i_block_lock   (i_block_lock),
		.i_am_match     (am_match),
		.i_match_vector (match_vector),
		.i_lock_thr     (i_rf_valid_am_thr),
		.i_unlock_thr   (i_rf_invalid_am_thr),
		.o_match_mask   (match_mask),
		.o_enable_mask  (enable_mask),
		.o_status       (status)
	);

	lane_id_decoder #(
		.N_ALIGNER (N_ALIGNER)
	) u_lane_id_decoder (
		.i_match_mask (match_mask),
		.o_lane_id    (o_lane_id)
	);

	bip_calculator u_bip_calculator (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_enable       (i_rf_enable),
		.i_valid        (i_valid),
		.i_block        (i_data),
		.i_period_start (status.start_of_lane | status.resync),   // restart per period
		.o_bip3         (calculated_bip)
	);

	am_error_counter #(
		.NB_ERROR_COUNTER (NB_ERROR_COUNTER)
	) u_am_error_counter (
		.i_clock          (i_clock),
		.i_reset          (i_reset),
		.i_enable         (i_rf_enable),
		.i_start_of_lane  (status.start_of_lane),
		.i_reset_count    (status.resync),
		.i_received_bip   (i_data.am.bip3),        // marker view of the block
		.i_calculated_bip (calculated_bip),
		.o_error_count    (o_error_counter)
	);

endmodule

`default_nettype wire

//--- source/am_error_counter.sv
`timescale 1ns/100ps
`default_nettype none

module am_error_counter
#(
	parameter int NB_ERROR_COUNTER = 32
)
(
	input  logic                               i_clock,
	input  logic                               i_reset,
	input  logic                               i_enable,          // from register file
	input  logic                               i_start_of_lane,   // locked marker step
	input  logic                               i_reset_count,     // resync clears
	input  logic [am_lock_pkg::NB_BIP-1:0]     i_received_bip,    // bip3 from marker
	input  logic [am_lock_pkg::NB_BIP-1:0]     i_calculated_bip,  // from bip calculator
	output logic [NB_ERROR_COUNTER-1:0]        o_error_count
);

	logic armed;                                 // a full period lies behind the marker
	logic mismatch;

	assign mismatch = (i_received_bip != i_calculated_bip);

	always_ff @(posedge i_clock)
	begin
		if (i_reset || i_reset_count)
		begin
			o_error_count <= '0;
			armed         <= 1'b0;
		end
		else if (i_enable && i_start_of_lane)
		begin
			armed <= 1'b1;                           // first locked marker opens period
			if (armed && mismatch && o_error_count != '1)
				o_error_count <= o_error_count + 1'b1;   // saturate at all ones
		end
	end

endmodule

`default_nettype wire

//--- source/bip_calculator.sv
`timescale 1ns/100ps
`default_nettype none

module bip_calculator
(
	input  logic                               i_clock,
	input  logic                               i_reset,
	input  logic                               i_enable,        // from register file
	input  logic                               i_valid,
	input  am_lock_pkg::coded_block_u          i_block,
	input  logic                               i_period_start,  // marker or resync
	output logic [am_lock_pkg::NB_BIP-1:0]     o_bip3           // parity up to this block
);

	am_lock_pkg::coded_block_u             masked_block;   // marker with bip fields zeroed
	logic [am_lock_pkg::NB_BIP-1:0]        bip_acc;

	// table 82-3 columns, ieee bit p sits at raw[65-p]
	// bit k of the result is parity column k
	function automatic logic [am_lock_pkg::NB_BIP-1:0] column_parity(
		input logic [am_lock_pkg::NB_CODED_BLOCK-1:0] blk);
		logic [am_lock_pkg::NB_BIP-1:0] par;
		int p;
		par = '0;
		for (p = 0; p < am_lock_pkg::NB_CODED_BLOCK; p++)
			if (p < 2)                                      // header bits join 3 and 4
				par[p+3] = par[p+3] ^ blk[am_lock_pkg::NB_CODED_BLOCK-1-p];
			else
				par[(p-2)%8] = par[(p-2)%8] ^ blk[am_lock_pkg::NB_CODED_BLOCK-1-p];
		return par;
	endfunction

	always_comb
	begin
		masked_block         = i_block;
		masked_block.am.bip3 = '0;
		masked_block.am.bip7 = '0;
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			bip_acc <= '0;
		else if (i_enable && i_valid)
		begin
			if (i_period_start)
				bip_acc <= column_parity(masked_block.raw);           // new period
			else
				bip_acc <= bip_acc ^ column_parity(i_block.raw);
		end
	end

	assign o_bip3 = bip_acc;                       // ready before the marker edge

endmodule

`default_nettype wire

//--- source/lane_id_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module lane_id_decoder
#(
	parameter int  N_ALIGNER  = 20,
	localparam int NB_LANE_ID = $clog2(N_ALIGNER)
)
(
	input  logic [N_ALIGNER-1:0]  i_match_mask,     // one-hot, all ones in search
	output logic [NB_LANE_ID-1:0] o_lane_id         // to lane reorder
);

	// lowest set bit wins, so an all ones mask reads as lane 0
	always_comb
	begin
		o_lane_id = '0;
		for (int i = N_ALIGNER - 1; i >= 0; i--)
			if (i_match_mask[i])
				o_lane_id = NB_LANE_ID'(i);
	end

endmodule

`default_nettype wire

//--- source/am_lock_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module am_lock_fsm
#(
	parameter int  N_ALIGNER  = 20,
	parameter int  N_BLOCKS   = 16383,            // data blocks between markers
	parameter int  MAX_VAL_AM = 20,
	parameter int  MAX_INV_AM = 8,
	localparam int NB_VAL_AM  = $clog2(MAX_VAL_AM),
	localparam int NB_INV_AM  = $clog2(MAX_INV_AM),
	localparam int NB_TIMER   = $clog2(N_BLOCKS + 1)
)
(
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_enable,           // from register file
	input  logic                    i_valid,            // one step per valid cycle
	input  logic                    i_block_lock,       // from block sync
	input  logic                    i_am_match,         // from comparator
	input  logic [N_ALIGNER-1:0]    i_match_vector,     // from comparator
	input  logic [NB_VAL_AM-1:0]    i_lock_thr,         // good markers to lock
	input  logic [NB_INV_AM-1:0]    i_unlock_thr,       // bad markers to unlock
	output logic [N_ALIGNER-1:0]    o_match_mask,       // to comparator and decoder
	output logic                    o_enable_mask,      // to comparator
	output am_lock_pkg::am_status_t o_status
);

	localparam logic [1:0] ST_SEARCH = 2'd0;
	localparam logic [1:0] ST_CHECK  = 2'd1;
	localparam logic [1:0] ST_LOCKED = 2'd2;

	logic [1:0]           state;
	logic [N_ALIGNER-1:0] lane_mask;            // one-hot lane, all ones in search
	logic [N_ALIGNER-1:0] first_hit;            // lowest matching entry
	logic [NB_TIMER-1:0]  timer;                // steps since last marker
	logic                 timer_done;           // expected marker position
	logic [NB_VAL_AM-1:0] val_count;
	logic [NB_VAL_AM:0]   val_next;             // extra bit keeps the carry
	logic [NB_INV_AM-1:0] inv_count;
	logic [NB_INV_AM:0]   inv_next;
	logic                 resync;

	assign first_hit  = i_match_vector & (~i_match_vector + 1'b1);
	assign timer_done = (timer == NB_TIMER'(N_BLOCKS));
	assign val_next   = val_count + 1'b1;
	assign inv_next   = inv_count + 1'b1;

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state     <= ST_SEARCH;
			lane_mask <= '1;
			timer     <= '0;
			val_count <= '0;
			inv_count <= '0;
			resync    <= 1'b0;
		end
		else if (!i_enable || !i_block_lock)            // immediate fallback
		begin
			state     <= ST_SEARCH;
			lane_mask <= '1;
			timer     <= '0;
			val_count <= '0;
			inv_count <= '0;
			resync    <= (state == ST_LOCKED);           // only a lost lock resyncs
		end
		else
		begin
			resync <= 1'b0;
			if (i_valid)                                // gaps freeze everything
			begin
				case (state)
				ST_SEARCH:
					if (i_am_match)
					begin
						lane_mask <= first_hit;                 // keep found lane
						val_count <= NB_VAL_AM'(1);
						timer     <= '0;
						state     <= (i_lock_thr <= NB_VAL_AM'(1)) ? ST_LOCKED : ST_CHECK;
					end
				ST_CHECK:
				begin
					timer <= timer_done ? '0 : timer + 1'b1;
					if (timer_done && i_am_match)
					begin
						val_count <= val_next[NB_VAL_AM-1:0];
						if (val_next >= i_lock_thr)
						begin
							state     <= ST_LOCKED;
							inv_count <= '0;
						end
					end
					else if (timer_done)                        // miss before lock
					begin
						state     <= ST_SEARCH;
						lane_mask <= '1;
						val_count <= '0;
					end
				end
				ST_LOCKED:
				begin
					timer <= timer_done ? '0 : timer + 1'b1;
					if (timer_done && i_am_match)
						inv_count <= '0;                        // good marker heals
					else if (timer_done && inv_next >= i_unlock_thr)
					begin
						state     <= ST_SEARCH;
						lane_mask <= '1;
						val_count <= '0;
						inv_count <= '0;
						resync    <= 1'b1;
					end
					else if (timer_done)
						inv_count <= inv_next[NB_INV_AM-1:0];
				end
				default:
					state <= ST_SEARCH;
				endcase
			end
		end
	end

	assign o_match_mask  = lane_mask;
	assign o_enable_mask = (state != ST_SEARCH);     // check only the kept lane

	assign o_status.am_lock       = (state == ST_LOCKED);
	assign o_status.resync        = resync;
	assign o_status.start_of_lane = i_valid && (state == ST_LOCKED) && timer_done;
	assign o_status.search        = (state == ST_SEARCH);

endmodule

`default_nettype wire

//--- source/am_lock_comparator.sv
`timescale 1ns/100ps
`default_nettype none

module am_lock_comparator
#(
	parameter int N_ALIGNER = 20                    // table entries searched
)
(
	input  am_lock_pkg::coded_block_u      i_block,          // block under test
	input  logic [am_lock_pkg::NB_AM-1:0]  i_compare_mask,   // 0 = don't care bit
	input  logic [N_ALIGNER-1:0]           i_match_mask,     // lane kept by fsm
	input  logic                           i_enable_mask,    // restrict to i_match_mask
	output logic                           o_am_match,
	output logic [N_ALIGNER-1:0]           o_match_vector    // one bit per table entry
);

	logic [am_lock_pkg::NB_AM-1:0] am_value;     // marker bytes without bip fields
	logic                          ctrl_sh;

	assign am_value = {i_block.am.m0, i_block.am.m1, i_block.am.m2,
		i_block.am.m4, i_block.am.m5, i_block.am.m6};
	assign ctrl_sh  = (i_block.am.sh == am_lock_pkg::CTRL_SH);   // markers are ctrl blocks

	for (genvar i = 0; i < N_ALIGNER; i++)
	begin : g_entry
		logic entry_en;                          // entry taking part in compare
		logic entry_hit;                         // masked pattern equal

		assign entry_en  = !i_enable_mask || i_match_mask[i];
		assign entry_hit =
			((am_value ^ am_lock_pkg::AM_TABLE[i]) & i_compare_mask) == '0;
		assign o_match_vector[i] = ctrl_sh && entry_en && entry_hit;
	end

	assign o_am_match = |o_match_vector;         // any enabled lane hit

endmodule

`default_nettype wire

//--- source/am_lock_pkg.sv
`default_nettype none

package am_lock_pkg;

	localparam int NB_CODED_BLOCK = 66;            // sync header plus 64 payload bits
	localparam int NB_AM          = 48;            // m0..m2 and m4..m6
	localparam int NB_BIP         = 8;
	localparam int N_AM_TABLE     = 20;            // lanes defined for 100G

	localparam logic [1:0] CTRL_SH         = 2'b10;   // control block header
	localparam logic [7:0] BLOCK_TYPE_CTRL = 8'h1E;   // all-control block type
	localparam logic [6:0] PCS_IDLE        = 7'h00;   // idle control character

	// idle control block put in place of a marker
	localparam logic [NB_CODED_BLOCK-1:0] IDLE_BLOCK =
		{CTRL_SH, BLOCK_TYPE_CTRL, {8{PCS_IDLE}}};

	// marker fields in transmit order, msb first
	typedef struct packed {
		logic [1:0] sh;                          // sync header
		logic [7:0] m0;
		logic [7:0] m1;
		logic [7:0] m2;
		logic [7:0] bip3;                        // parity over previous period
		logic [7:0] m4;                          // m4..m6 are m0..m2 inverted
		logic [7:0] m5;
		logic [7:0] m6;
		logic [7:0] bip7;                        // inverse of bip3
	} am_fields_t;

	typedef union packed {
		logic [NB_CODED_BLOCK-1:0] raw;          // data path view
		am_fields_t                am;           // marker view
	} coded_block_u;

	// {m0,m1,m2,m4,m5,m6} per lane
	localparam logic [NB_AM-1:0] AM_TABLE [0:N_AM_TABLE-1] = '{
		48'hC16821_3E97DE,                       // lane 0
		48'h9D718E_628E71,
		48'h594BE8_A6B417,
		48'h4D957B_B26A84,
		48'hF50709_0AF8F6,
		48'hDD14C2_22EB3D,                       // lane 5
		48'h9A4A26_65B5D9,
		48'h7B4566_84BA99,
		48'hA02476_5FDB89,
		48'h68C9FB_973604,
		48'hFD6C99_029366,                       // lane 10
		48'hB99155_466EAA,
		48'h5CB9B2_A3464D,
		48'h1AF8BD_E50742,
		48'h83C7CA_7C3835,
		48'h3536CD_CAC932,                       // lane 15
		48'hC4314C_3BCEB3,
		48'hADD6B7_522948,
		48'h5F662A_A099D5,
		48'hC0F0E5_3F0F1A                        // lane 19
	};

	typedef struct packed {
		logic am_lock;                           // marker lock reached
		logic resync;                            // one cycle pulse on lock loss
		logic start_of_lane;                     // locked marker on this step
		logic search;                            // fsm hunting for a marker
	} am_status_t;

endpackage

`default_nettype wire
